/* src/hscale_consts.svh */
`ifndef HSCALE_CONSTS_SVH
`define HSCALE_CONSTS_SVH

// one colour sample
`define HS_PIXEL_WIDTH 12

// coefficient magnitude where 512 is unity weight
`define HS_COE_WIDTH 10

// scale step in fixed point where 4096 is 1.0
`define HS_SCALE_ONE 4096
`define HS_STEP_WIDTH 16

// phase table address from position bits 11..2
`define HS_PHASE_WIDTH 10
`define HS_TABLE_SIZE 1024

// line position and reported line length
`define HS_POS_WIDTH 24
`define HS_LEN_WIDTH 14

`endif

/* src/hscale_pkg.sv */
`include "hscale_consts.svh"

package hscale_pkg;

    typedef logic [`HS_PIXEL_WIDTH-1:0] pixel_t;
    typedef logic [`HS_COE_WIDTH-1:0]   coe_t;
    typedef logic [`HS_STEP_WIDTH-1:0]  step_t;
    typedef logic [`HS_PHASE_WIDTH-1:0] phase_t;
    typedef logic [`HS_POS_WIDTH-1:0]   pos_t;
    typedef logic [`HS_LEN_WIDTH-1:0]   len_t;

    // one beat of the raster stream
    typedef struct packed {
        logic   de;
        logic   hs;
        logic   vs;
        pixel_t pix;
    } video_t;

endpackage

/* src/step_ctrl.sv */
`timescale 1ns/1ns
`include "hscale_consts.svh"

module step_ctrl (
    input  logic               clk,
    input  logic               arst_n_i,
    input  hscale_pkg::video_t video_i,
    input  hscale_pkg::step_t  scale_step_i,
    output hscale_pkg::video_t video_o,
    output hscale_pkg::step_t  step_o
);
    import hscale_pkg::*;

    // allowed step range is 1.0 up to just below 4.0
    localparam step_t STEP_MIN = step_t'(`HS_SCALE_ONE);
    localparam step_t STEP_MAX = step_t'(4 * `HS_SCALE_ONE - 1);

    logic   de_q;
    logic   hs_q;
    logic   vs_q;
    pixel_t pix_q;
    logic   frame_start;
    step_t  step_clip;

    // vs_q holds last cycle's vs
    assign frame_start = video_i.vs & ~vs_q;

    always_comb begin
        if (scale_step_i < STEP_MIN) begin
            step_clip = STEP_MIN;
        end else if (scale_step_i > STEP_MAX) begin
            step_clip = STEP_MAX;
        end else begin
            step_clip = scale_step_i;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            de_q   <= 1'b0;
            hs_q   <= 1'b0;
            vs_q   <= 1'b0;
            step_o <= STEP_MIN;
        end else begin
            de_q <= video_i.de;
            hs_q <= video_i.hs;
            vs_q <= video_i.vs;
            // new step lands together with the first vs beat
            if (frame_start) begin
                step_o <= step_clip;
            end
        end
    end

    always_ff @(posedge clk) begin
        pix_q <= video_i.pix;
    end

    assign video_o = '{de: de_q, hs: hs_q, vs: vs_q, pix: pix_q};

endmodule

/* src/cubic_table.sv */
`timescale 1ns/1ns
`include "hscale_consts.svh"

module cubic_table (
    input  logic                   clk,
    input  hscale_pkg::phase_t     phase_i,
    output hscale_pkg::coe_t [3:0] coe_o
);
    import hscale_pkg::*;

    // unity weight as a real
    localparam real COE_ONE = 2.0 ** (`HS_COE_WIDTH - 1);

    // entry holds c0..c3 for one phase
    coe_t [3:0] rom [`HS_TABLE_SIZE];

    // scale a weight and round to nearest
    function automatic coe_t to_coe(input real w);
        return coe_t'($rtoi(w * COE_ONE + 0.5));
    endfunction

    // weights of the cubic kernel at phase t
    // c0 and c3 are magnitudes of the negative outer taps
    initial begin
        real t;
        real t2;
        real t3;
        for (int i = 0; i < `HS_TABLE_SIZE; i++) begin
            t  = real'(i) / real'(`HS_TABLE_SIZE);
            t2 = t * t;
            t3 = t2 * t;
            rom[i][0] = to_coe(0.5 * t2 - 0.5 * t3);
            rom[i][1] = to_coe(-1.5 * t3 + 2.0 * t2 + 0.5 * t);
            rom[i][2] = to_coe(1.5 * t3 - 2.5 * t2 + 1.0);
            rom[i][3] = to_coe(0.5 * t - t2 + 0.5 * t3);
        end
    end

    // registered read every clock
    always_ff @(posedge clk) begin
        coe_o <= rom[phase_i];
    end

endmodule

/* src/hscale_core.sv */
`timescale 1ns/1ns
`include "hscale_consts.svh"

module hscale_core (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  hscale_pkg::video_t     video_i,
    input  hscale_pkg::step_t      step_i,
    output hscale_pkg::phase_t     phase_o,
    input  hscale_pkg::coe_t [3:0] coe_i,
    output hscale_pkg::video_t     video_o
);
    import hscale_pkg::*;

    localparam int PIX_W  = `HS_PIXEL_WIDTH;
    localparam int COE_W  = `HS_COE_WIDTH;
    localparam int MULT_W = PIX_W + COE_W;
    localparam int SUM_W  = MULT_W + 3;
    localparam int DELAY  = 5;

    // half of the unity weight for round to nearest
    localparam logic [MULT_W:0] ROUND = (MULT_W + 1)'(1 << (COE_W - 2));

    typedef struct packed {
        logic de;
        logic hs;
        logic vs;
    } ctrl_t;

    pos_t                    in_cnt;
    pos_t                    out_pos;
    logic                    hs_prev;
    logic                    line_start;
    logic                    emit;
    pixel_t                  hist [3];
    pixel_t                  tap [4];
    ctrl_t                   ctrl_q [DELAY];
    logic [MULT_W-1:0]       mult [4];
    logic [MULT_W:0]         pos_sum;
    logic [MULT_W:0]         neg_sum;
    logic signed [SUM_W-1:0] sum;
    pixel_t                  pix_q;

    assign line_start = video_i.hs & ~hs_prev;

    // one output at most per input pixel
    assign emit = video_i.de & ~line_start & (in_cnt > out_pos);

    // fractional part of the output position addresses the table
    assign phase_o = out_pos[`HS_PHASE_WIDTH+1:2];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hs_prev <= 1'b0;
            in_cnt  <= '0;
            out_pos <= pos_t'(`HS_SCALE_ONE);
        end else begin
            hs_prev <= video_i.hs;
            if (line_start) begin
                in_cnt  <= '0;
                out_pos <= pos_t'(`HS_SCALE_ONE);
            end else begin
                if (video_i.de) begin
                    in_cnt <= in_cnt + pos_t'(`HS_SCALE_ONE);
                end
                if (emit) begin
                    out_pos <= out_pos + pos_t'(step_i);
                end
            end
        end
    end

    // timing travels alongside the samples in flight
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < DELAY; i++) begin
                ctrl_q[i] <= '0;
            end
        end else begin
            ctrl_q[0] <= '{de: emit, hs: video_i.hs, vs: video_i.vs};
            for (int i = 1; i < DELAY; i++) begin
                ctrl_q[i] <= ctrl_q[i-1];
            end
        end
    end

    // pixel history, zero before the line begins
    always_ff @(posedge clk) begin
        if (line_start) begin
            hist[0] <= '0;
            hist[1] <= '0;
            hist[2] <= '0;
        end else if (video_i.de) begin
            hist[0] <= video_i.pix;
            hist[1] <= hist[0];
            hist[2] <= hist[1];
        end
        if (emit) begin
            tap[0] <= video_i.pix;
            tap[1] <= hist[0];
            tap[2] <= hist[1];
            tap[3] <= hist[2];
        end
    end

    // taps meet the coefficients one cycle after the address
    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            mult[i] <= MULT_W'(coe_i[i]) * MULT_W'(tap[i]);
        end

        // inner taps add and outer taps subtract
        pos_sum <= (MULT_W + 1)'(mult[1]) + (MULT_W + 1)'(mult[2]) + ROUND;
        neg_sum <= (MULT_W + 1)'(mult[0]) + (MULT_W + 1)'(mult[3]);

        sum <= $signed({2'b00, pos_sum}) - $signed({2'b00, neg_sum});

        // clamp to the pixel range
        if (sum[SUM_W-1]) begin
            pix_q <= '0;
        end else if (|sum[SUM_W-2:MULT_W-1]) begin
            pix_q <= '1;
        end else begin
            pix_q <= sum[COE_W-1 +: PIX_W];
        end
    end

    assign video_o = '{
        de:  ctrl_q[DELAY-1].de,
        hs:  ctrl_q[DELAY-1].hs,
        vs:  ctrl_q[DELAY-1].vs,
        pix: pix_q
    };

endmodule

/* src/line_len_stage.sv */
`timescale 1ns/1ns

module line_len_stage (
    input  logic               clk,
    input  logic               arst_n_i,
    input  hscale_pkg::video_t video_i,
    output hscale_pkg::video_t video_o,
    output hscale_pkg::len_t   line_len_o,
    output logic               line_len_valid_o
);
    import hscale_pkg::*;

    logic   de_q;
    logic   hs_q;
    logic   vs_q;
    pixel_t pix_q;
    len_t   beat_cnt;
    logic   line_end;

    // output de is sparse when downscaling
    // so the next hs start closes a line that had beats
    assign line_end = video_i.hs & ~hs_q & (beat_cnt != '0);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            de_q             <= 1'b0;
            hs_q             <= 1'b0;
            vs_q             <= 1'b0;
            beat_cnt         <= '0;
            line_len_valid_o <= 1'b0;
        end else begin
            de_q             <= video_i.de;
            hs_q             <= video_i.hs;
            vs_q             <= video_i.vs;
            line_len_valid_o <= line_end;
            if (line_end) begin
                beat_cnt <= len_t'(video_i.de);
            end else if (video_i.de) begin
                beat_cnt <= beat_cnt + len_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        pix_q <= video_i.pix;
        if (line_end) begin
            line_len_o <= beat_cnt;
        end
    end

    assign video_o = '{de: de_q, hs: hs_q, vs: vs_q, pix: pix_q};

endmodule

/* src/hscale_top.sv */
`timescale 1ns/1ns

module hscale_top (
    input  logic               clk,
    input  logic               arst_n_i,
    input  hscale_pkg::video_t video_i,
    input  hscale_pkg::step_t  scale_step_i,
    output hscale_pkg::video_t video_o,
    output hscale_pkg::len_t   line_len_o,
    output logic               line_len_valid_o
);
    import hscale_pkg::*;

    video_t     video_s;
    step_t      step_s;
    phase_t     phase_s;
    coe_t [3:0] coe_s;
    video_t     filt_s;

    // step held per frame
    step_ctrl step_ctrl0 (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .video_i      (video_i),
        .scale_step_i (scale_step_i),
        .video_o      (video_s),
        .step_o       (step_s)
    );

    hscale_core hscale_core0 (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .video_i  (video_s),
        .step_i   (step_s),
        .phase_o  (phase_s),
        .coe_i    (coe_s),
        .video_o  (filt_s)
    );

    cubic_table cubic_table0 (
        .clk     (clk),
        .phase_i (phase_s),
        .coe_o   (coe_s)
    );

    // output register and per-line count
    line_len_stage line_len_stage0 (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .video_i          (filt_s),
        .video_o          (video_o),
        .line_len_o       (line_len_o),
        .line_len_valid_o (line_len_valid_o)
    );

endmodule

/* test/hscale_sva.sv */
`timescale 1ns/1ns

module hscale_sva (
    input logic               clk,
    input logic               arst_n_i,
    input hscale_pkg::video_t video_i,
    input hscale_pkg::video_t out_video_i,
    input logic               len_valid_i
);
    // video_i to video_o
    localparam int LATENCY = 7;

    // output timing idle while reset is held
    property quiet_in_reset;
        @(posedge clk) !arst_n_i |-> !out_video_i.de && !out_video_i.hs && !out_video_i.vs;
    endproperty

    property len_valid_single;
        @(posedge clk) disable iff (!arst_n_i) len_valid_i |=> !len_valid_i;
    endproperty

    property hs_latency;
        @(posedge clk) disable iff (!arst_n_i) out_video_i.hs == $past(video_i.hs, LATENCY);
    endproperty

    quiet_in_reset_a: assert property (quiet_in_reset)
        else $error("video output timing not idle during reset");

    len_valid_single_a: assert property (len_valid_single)
        else $error("line length valid held for more than one cycle");

    hs_latency_a: assert property (hs_latency)
        else $error("output hs does not follow input hs after the fixed latency");

endmodule

bind hscale_top hscale_sva sva0 (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .video_i     (video_i),
    .out_video_i (video_o),
    .len_valid_i (line_len_valid_o)
);

/* test/hscale_tb.sv */
`timescale 1ns/1ns
`include "hscale_consts.svh"

module hscale_tb;
    import hscale_pkg::*;

    localparam int ONE       = `HS_SCALE_ONE;
    localparam int PIX_MAX   = (1 << `HS_PIXEL_WIDTH) - 1;
    localparam int LATENCY   = 7;
    localparam int DRAIN_MAX = 200;

    logic   clk;
    logic   arst_n_i;
    video_t video_i;
    step_t  scale_step_i;
    video_t video_o;
    len_t   line_len_o;
    logic   line_len_valid_o;

    integer     seed;
    int         coe_tab [`HS_TABLE_SIZE][4];
    int         line_pix [256];
    int         exp_pix [$];
    int         exp_len [$];
    logic [1:0] sync_dly [LATENCY];
    string      test_name;
    int         step_cur;
    int         checks;
    int         errors;
    int         tests;
    int         chk_start;
    int         err_start;
    int         clamp_lo;
    int         clamp_hi;
    bit         timed_out;

    hscale_top dut0 (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .video_i          (video_i),
        .scale_step_i     (scale_step_i),
        .video_o          (video_o),
        .line_len_o       (line_len_o),
        .line_len_valid_o (line_len_valid_o)
    );

    always #5 clk = ~clk;

    task automatic check_value(input string what, input int expected, input int actual);
        checks++;
        if (expected != actual) begin
            errors++;
            $display("mismatch in %s, %s: expected %0d, actual %0d",
                     test_name, what, expected, actual);
        end
    endtask

    // cubic kernel weights scaled by 512, rounded to nearest
    task automatic build_table();
        real t;
        for (int i = 0; i < `HS_TABLE_SIZE; i++) begin
            t = real'(i) / real'(`HS_TABLE_SIZE);
            coe_tab[i][0] = $rtoi((0.5 * t * t - 0.5 * t * t * t) * 512.0 + 0.5);
            coe_tab[i][1] = $rtoi((-1.5 * t * t * t + 2.0 * t * t + 0.5 * t) * 512.0 + 0.5);
            coe_tab[i][2] = $rtoi((1.5 * t * t * t - 2.5 * t * t + 1.0) * 512.0 + 0.5);
            coe_tab[i][3] = $rtoi((0.5 * t - t * t + 0.5 * t * t * t) * 512.0 + 0.5);
        end
    endtask

    // rounded sum before the clamp, negative when the sum is
    function automatic int filter_value(input int n, input int phase);
        int tap [4];
        int sum;
        for (int k = 0; k < 4; k++) begin
            tap[k] = (n - k >= 0) ? line_pix[n - k] : 0;
        end
        sum = coe_tab[phase][1] * tap[1] + coe_tab[phase][2] * tap[2]
            - coe_tab[phase][0] * tap[0] - coe_tab[phase][3] * tap[3] + 256;
        return sum >>> 9;
    endfunction

    task automatic model_line(input int n_pix);
        int pos;
        int cnt;
        int v;
        pos = ONE;
        cnt = 0;
        for (int n = 0; n < n_pix; n++) begin
            if (n * ONE > pos) begin
                v = filter_value(n, (pos >> 2) % `HS_TABLE_SIZE);
                if (v < 0) begin
                    v = 0;
                    clamp_lo++;
                end else if (v > PIX_MAX) begin
                    v = PIX_MAX;
                    clamp_hi++;
                end
                exp_pix.push_back(v);
                pos += step_cur;
                cnt++;
            end
        end
        exp_len.push_back(cnt);
    endtask

    task automatic drive_beat(input logic de, input logic hs, input logic vs, input int pix);
        @(posedge clk);
        video_i <= '{de: de, hs: hs, vs: vs, pix: pixel_t'(pix)};
    endtask

    function automatic int random_step();
        return ONE + int'($unsigned($random(seed)) % (3 * ONE));
    endfunction

    task automatic run_line(input int n_pix, input bit gaps, input bit extreme);
        for (int n = 0; n < n_pix; n++) begin
            if (extreme) begin
                line_pix[n] = ($random(seed) & 1) ? PIX_MAX : 0;
            end else begin
                line_pix[n] = int'($unsigned($random(seed)) % (PIX_MAX + 1));
            end
        end
        model_line(n_pix);
        // hs pulse in blanking, then the active part
        drive_beat(1'b0, 1'b1, 1'b0, 0);
        drive_beat(1'b0, 1'b1, 1'b0, 0);
        drive_beat(1'b0, 1'b0, 1'b0, 0);
        drive_beat(1'b0, 1'b0, 1'b0, 0);
        for (int n = 0; n < n_pix; n++) begin
            if (gaps && ($random(seed) & 3) == 0) begin
                repeat (1 + int'($unsigned($random(seed)) % 3)) begin
                    drive_beat(1'b0, 1'b0, 1'b0, int'($unsigned($random(seed)) % 4096));
                end
            end
            drive_beat(1'b1, 1'b0, 1'b0, line_pix[n]);
        end
        repeat (4) drive_beat(1'b0, 1'b0, 1'b0, 0);
    endtask

    task automatic run_frame(input int step, input int n_lines, input bit gaps,
                             input bit extreme, input bit change_mid);
        drive_beat(1'b0, 1'b0, 1'b0, 0);
        scale_step_i <= step_t'(step);
        drive_beat(1'b0, 1'b0, 1'b1, 0);
        drive_beat(1'b0, 1'b0, 1'b1, 0);
        step_cur = step;
        drive_beat(1'b0, 1'b0, 1'b0, 0);
        for (int l = 0; l < n_lines; l++) begin
            // any value here must wait for the next frame start
            if (change_mid && l == 1) begin
                scale_step_i <= step_t'($random(seed));
            end
            run_line(8 + int'($unsigned($random(seed)) % 193), gaps, extreme);
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        chk_start = checks;
        err_start = errors;
        clamp_lo = 0;
        clamp_hi = 0;
    endtask

    task automatic finish_test();
        int wait_cnt;
        // an empty line start flushes the last line length
        drive_beat(1'b0, 1'b1, 1'b0, 0);
        drive_beat(1'b0, 1'b1, 1'b0, 0);
        drive_beat(1'b0, 1'b0, 1'b0, 0);
        wait_cnt = 0;
        while ((exp_pix.size() != 0 || exp_len.size() != 0) && wait_cnt < DRAIN_MAX) begin
            @(posedge clk);
            wait_cnt++;
        end
        if (exp_pix.size() != 0 || exp_len.size() != 0) begin
            timed_out = 1'b1;
            $display("timeout in %s: %0d pixels and %0d line lengths never came out",
                     test_name, exp_pix.size(), exp_len.size());
        end
        tests++;
        $display("test %s finished: %0d checks, %0d errors",
                 test_name, checks - chk_start, errors - err_start);
    endtask

    // outputs sampled mid cycle, away from the driving edge
    always @(negedge clk) begin
        if (arst_n_i) begin
            check_value("hs delay", int'(sync_dly[LATENCY-1][1]), int'(video_o.hs));
            check_value("vs delay", int'(sync_dly[LATENCY-1][0]), int'(video_o.vs));
            if (video_o.de) begin
                if (exp_pix.size() == 0) begin
                    errors++;
                    $display("unexpected output pixel %0d in %s with none expected",
                             video_o.pix, test_name);
                end else begin
                    check_value("pixel", exp_pix.pop_front(), int'(video_o.pix));
                end
            end
            if (line_len_valid_o) begin
                if (exp_len.size() == 0) begin
                    errors++;
                    $display("unexpected line length report in %s", test_name);
                end else begin
                    check_value("line length", exp_len.pop_front(), int'(line_len_o));
                end
            end
        end
        for (int i = LATENCY - 1; i > 0; i--) begin
            sync_dly[i] = sync_dly[i-1];
        end
        sync_dly[0] = {video_i.hs, video_i.vs};
    end

    initial begin
        seed = 32'h1813;
        clk = 1'b0;
        arst_n_i = 1'b0;
        video_i = '0;
        scale_step_i = step_t'(ONE);
        checks = 0;
        errors = 0;
        tests = 0;
        timed_out = 1'b0;
        test_name = "reset";
        for (int i = 0; i < LATENCY; i++) begin
            sync_dly[i] = '0;
        end
        build_table();
        repeat (3) @(posedge clk);
        arst_n_i <= 1'b1;
        repeat (2) drive_beat(1'b0, 1'b0, 1'b0, 0);

        start_test("unity_step");
        run_frame(ONE, 3, 1'b0, 1'b0, 1'b0);
        finish_test();

        if (!timed_out) begin
            start_test("random_steps");
            repeat (4) run_frame(random_step(), 3, 1'b0, 1'b0, 1'b0);
            finish_test();
        end

        if (!timed_out) begin
            start_test("step_change");
            repeat (3) run_frame(random_step(), 3, 1'b0, 1'b0, 1'b1);
            finish_test();
        end

        if (!timed_out) begin
            start_test("gaps_clamp");
            repeat (3) run_frame(random_step(), 3, 1'b1, 1'b1, 1'b0);
            if (clamp_lo == 0 || clamp_hi == 0) begin
                errors++;
                $display("gaps_clamp produced no expected output clamped to both 0 and 4095");
            end
            finish_test();
        end

        if (!timed_out) begin
            start_test("timing");
            repeat (2) run_frame(random_step(), 4, 1'b1, 1'b0, 1'b0);
            finish_test();
        end

        $display("tests run: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+src
src/hscale_pkg.sv
src/step_ctrl.sv
src/cubic_table.sv
src/hscale_core.sv
src/line_len_stage.sv
src/hscale_top.sv
test/hscale_sva.sv
test/hscale_tb.sv

/* Makefile */
# Verilator flow for the horizontal scaler testbench

VERILATOR ?= verilator
TOP       ?= hscale_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --timing --assert
PASS_MSG  ?= SIMULATION PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
		-Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only if the pass line shows up in the output
run: build
	@out="$$($(OBJ_DIR)/V$(TOP))"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only -Wall $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
